// File: files.f
hdl/core_pkg.sv
hdl/stage_reg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/hazard_bypass.sv
hdl/execute_unit.sv
hdl/memory_unit.sv
hdl/pipeline_core.sv
tests/tb_core_props.sv
tests/tb_core.sv

// File: hdl/core_pkg.sv
////////////////////
// core package
// widths, opcodes, alu ops and the stage payloads of the rv64i pipeline
////////////////////
package core_pkg;

    parameter int XLEN       = 64;
    parameter int ILEN       = 32;
    parameter int REG_ADDR_W = 5;

    // major opcodes of the supported subset
    parameter logic [6:0] OP_LUI    = 7'b0110111;
    parameter logic [6:0] OP_OP_IMM = 7'b0010011;
    parameter logic [6:0] OP_OP     = 7'b0110011;
    parameter logic [6:0] OP_LOAD   = 7'b0000011;
    parameter logic [6:0] OP_STORE  = 7'b0100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    ////////////////////
    // stage payloads
    ////////////////////
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
    } id_payload_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [ILEN-1:0]       instr;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       st_data;   // rs2 value for sd
        logic                  is_load;
        logic                  is_store;
    } ex_payload_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [ILEN-1:0]       instr;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic                  is_load;
        logic                  is_store;
        logic [XLEN-1:0]       alu_res;   // also the memory address
        logic [XLEN-1:0]       st_data;
    } m_payload_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [ILEN-1:0]       instr;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       wdata;
    } wb_payload_t;

endpackage

// File: hdl/decode_unit.sv
////////////////////
// decode unit
// opcode decode, immediates and operand placement for execute
////////////////////
module decode_unit (
    input  logic                            valid_i,
    input  core_pkg::id_payload_t           data_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                            use_rs1_o,
    output logic                            use_rs2_o,
    input  logic [core_pkg::XLEN-1:0]       rs1_val_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_val_i,
    output core_pkg::ex_payload_t           ex_data_o
);
    import core_pkg::*;

    logic [ILEN-1:0]       instr;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm_i, imm_s, imm_u;
    logic                  legal, uses1, uses2, writes, ld, st;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       op_a, op_b;

    assign instr  = data_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        legal  = 1'b1;
        uses1  = 1'b1;
        uses2  = 1'b0;
        writes = 1'b1;
        ld     = 1'b0;
        st     = 1'b0;
        alu_op = ALU_ADD;
        op_a   = rs1_val_i;
        op_b   = imm_i;
        case (opcode)
            OP_LUI: begin
                uses1  = 1'b0;
                alu_op = ALU_PASS_B;
                op_a   = '0;
                op_b   = imm_u;
            end
            OP_OP_IMM: begin
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: legal = 1'b0;  // slti, shifts etc
                endcase
            end
            OP_OP: begin
                uses2 = 1'b1;
                op_b  = rs2_val_i;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op = ALU_SUB;
                    {7'b0000000, 3'b100}: alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: alu_op = ALU_AND;
                    default:              legal = 1'b0;
                endcase
            end
            OP_LOAD: begin
                ld    = 1'b1;
                legal = (funct3 == 3'b011);  // ld only
            end
            OP_STORE: begin
                uses2  = 1'b1;
                writes = 1'b0;
                st     = 1'b1;
                op_b   = imm_s;
                legal  = (funct3 == 3'b011);  // sd only
            end
            default: legal = 1'b0;
        endcase
    end

    // illegal opcodes become bubbles: no reads, no write, no access
    assign use_rs1_o = valid_i && legal && uses1;
    assign use_rs2_o = valid_i && legal && uses2;

    always_comb begin
        ex_data_o.pc       = data_i.pc;
        ex_data_o.instr    = instr;
        ex_data_o.wen      = legal && writes && (rd != '0);  // x0 never written
        ex_data_o.rd       = ex_data_o.wen ? rd : '0;
        ex_data_o.alu_op   = alu_op;
        ex_data_o.op_a     = op_a;
        ex_data_o.op_b     = op_b;
        ex_data_o.st_data  = rs2_val_i;
        ex_data_o.is_load  = legal && ld;
        ex_data_o.is_store = legal && st;
    end

endmodule

// File: hdl/execute_unit.sv
////////////////////
// execute unit
// alu, also forms load/store addresses
////////////////////
module execute_unit (
    input  core_pkg::ex_payload_t     data_i,
    output logic [core_pkg::XLEN-1:0] result_o,
    output core_pkg::m_payload_t      m_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0] a, b;

    assign a = data_i.op_a;
    assign b = data_i.op_b;

    always_comb begin
        case (data_i.alu_op)
            ALU_ADD:    result_o = a + b;  // ld/sd address too
            ALU_SUB:    result_o = a - b;
            ALU_XOR:    result_o = a ^ b;
            ALU_OR:     result_o = a | b;
            ALU_AND:    result_o = a & b;
            ALU_PASS_B: result_o = b;
            default:    result_o = '0;
        endcase
    end

    always_comb begin
        m_data_o.pc       = data_i.pc;
        m_data_o.instr    = data_i.instr;
        m_data_o.rd       = data_i.rd;
        m_data_o.wen      = data_i.wen;
        m_data_o.is_load  = data_i.is_load;
        m_data_o.is_store = data_i.is_store;
        m_data_o.alu_res  = result_o;
        m_data_o.st_data  = data_i.st_data;
    end

endmodule

// File: hdl/fetch_unit.sv
////////////////////
// fetch unit
// sequential program counter, no branches
////////////////////
module fetch_unit #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      hold_i,
    output logic [core_pkg::XLEN-1:0] pc_o
);
    import core_pkg::*;

    logic [XLEN-1:0] pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!hold_i) begin
            pc_q <= pc_q + XLEN'(4);  // next word
        end
    end

    assign pc_o = pc_q;

endmodule

// File: hdl/hazard_bypass.sv
////////////////////
// hazard detection and operand bypass
// ex over m over wb, load-use stall on an ex match
////////////////////
module hazard_bypass (
    input  logic                            id_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                            use_rs1_i,
    input  logic                            use_rs2_i,
    input  logic [core_pkg::XLEN-1:0]       rf_rs1_i,
    input  logic [core_pkg::XLEN-1:0]       rf_rs2_i,
    input  logic                            ex_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic                            ex_wen_i,
    input  logic                            ex_is_load_i,
    input  logic [core_pkg::XLEN-1:0]       ex_result_i,
    input  logic                            m_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] m_rd_i,
    input  logic                            m_wen_i,
    input  logic [core_pkg::XLEN-1:0]       m_result_i,
    input  logic                            wb_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic                            wb_wen_i,
    input  logic [core_pkg::XLEN-1:0]       wb_result_i,
    output logic [core_pkg::XLEN-1:0]       rs1_val_o,
    output logic [core_pkg::XLEN-1:0]       rs2_val_o,
    output logic                            stall_o
);
    import core_pkg::*;

    logic [REG_ADDR_W-1:0] rs [2];
    logic [XLEN-1:0]       rf_val [2];
    logic [XLEN-1:0]       val [2];
    logic [1:0]            need, ex_hit, m_hit, wb_hit;

    assign rs[0]     = rs1_i;
    assign rs[1]     = rs2_i;
    assign rf_val[0] = rf_rs1_i;
    assign rf_val[1] = rf_rs2_i;
    assign need      = {use_rs2_i && rs2_i != '0, use_rs1_i && rs1_i != '0};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ex_hit[i] = id_valid_i && need[i] && ex_valid_i && ex_wen_i && ex_rd_i == rs[i];
            m_hit[i]  = id_valid_i && need[i] && m_valid_i && m_wen_i && m_rd_i == rs[i];
            wb_hit[i] = id_valid_i && need[i] && wb_valid_i && wb_wen_i && wb_rd_i == rs[i];
            if (ex_hit[i]) begin
                val[i] = ex_result_i;  // youngest producer wins
            end else if (m_hit[i]) begin
                val[i] = m_result_i;
            end else if (wb_hit[i]) begin
                val[i] = wb_result_i;
            end else begin
                val[i] = rf_val[i];
            end
        end
    end

    assign rs1_val_o = val[0];
    assign rs2_val_o = val[1];
    assign stall_o   = ex_is_load_i && (|ex_hit);  // load data not ready until m

endmodule

// File: hdl/memory_unit.sv
////////////////////
// memory unit
// data port driver, holds m until the access completes
////////////////////
module memory_unit (
    input  logic                      valid_i,
    input  core_pkg::m_payload_t      data_i,
    output logic                      dmem_req_o,
    output logic                      dmem_wen_o,
    output logic [core_pkg::XLEN-1:0] dmem_addr_o,
    output logic [core_pkg::XLEN-1:0] dmem_wdata_o,
    input  logic [core_pkg::XLEN-1:0] dmem_rdata_i,
    input  logic                      dmem_ready_i,
    output logic                      mem_busy_o,
    output logic [core_pkg::XLEN-1:0] result_o,
    output core_pkg::wb_payload_t     wb_data_o
);

    assign dmem_req_o   = valid_i && (data_i.is_load || data_i.is_store);
    assign dmem_wen_o   = valid_i && data_i.is_store;
    assign dmem_addr_o  = data_i.alu_res;
    assign dmem_wdata_o = data_i.st_data;

    // waiting on the port stalls everything from m back
    assign mem_busy_o = dmem_req_o && !dmem_ready_i;

    assign result_o = data_i.is_load ? dmem_rdata_i : data_i.alu_res;

    always_comb begin
        wb_data_o.pc    = data_i.pc;
        wb_data_o.instr = data_i.instr;
        wb_data_o.rd    = data_i.rd;
        wb_data_o.wen   = data_i.wen;
        wb_data_o.wdata = result_o;
    end

endmodule

// File: hdl/pipeline_core.sv
////////////////////
// pipeline core
// five-stage in-order rv64i subset with bypass and commit port
////////////////////
module pipeline_core #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    output logic [core_pkg::XLEN-1:0]       imem_addr_o,
    input  logic [core_pkg::ILEN-1:0]       imem_data_i,
    output logic                            dmem_req_o,
    output logic                            dmem_wen_o,
    output logic [core_pkg::XLEN-1:0]       dmem_addr_o,
    output logic [core_pkg::XLEN-1:0]       dmem_wdata_o,
    input  logic [core_pkg::XLEN-1:0]       dmem_rdata_i,
    input  logic                            dmem_ready_i,
    output logic                            wb_commit_o,
    output logic [core_pkg::XLEN-1:0]       wb_pc_o,
    output logic [core_pkg::ILEN-1:0]       wb_instr_o,
    output logic                            wb_wen_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [core_pkg::XLEN-1:0]       wb_wdata_o
);
    import core_pkg::*;

    id_payload_t           id_d, id_q;
    ex_payload_t           ex_d, ex_q;
    m_payload_t            m_d, m_q;
    wb_payload_t           wb_d, wb_q;
    logic                  id_valid, ex_valid, m_valid, wb_valid;
    logic                  stall, mem_busy, front_hold;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1, rs2;
    logic                  use_rs1, use_rs2;
    logic [XLEN-1:0]       rf_rs1, rf_rs2, rs1_val, rs2_val;
    logic [XLEN-1:0]       ex_result, m_result;

    assign front_hold = stall || mem_busy;

    ////////////////////
    // fetch and decode
    ////////////////////
    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (front_hold),
        .pc_o    (pc)
    );

    assign imem_addr_o = pc;
    assign id_d.pc     = pc;
    assign id_d.instr  = imem_data_i;  // same-cycle instruction port

    stage_reg #(.payload_t(id_payload_t)) id_reg (
        .clk(clk), .rst_n_i(rst_n_i), .en_i(!front_hold),
        .valid_i(1'b1), .data_i(id_d), .valid_o(id_valid), .data_o(id_q)
    );

    decode_unit u_decode (
        .valid_i   (id_valid),
        .data_i    (id_q),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .use_rs1_o (use_rs1),
        .use_rs2_o (use_rs2),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .ex_data_o (ex_d)
    );

    reg_file u_rf (
        .clk       (clk),
        .ra_addr_i (rs1),
        .rb_addr_i (rs2),
        .ra_data_o (rf_rs1),
        .rb_data_o (rf_rs2),
        .w_en_i    (wb_valid && wb_q.wen),
        .w_addr_i  (wb_q.rd),
        .w_data_i  (wb_q.wdata)
    );

    hazard_bypass u_hazard (
        .id_valid_i   (id_valid),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .use_rs1_i    (use_rs1),
        .use_rs2_i    (use_rs2),
        .rf_rs1_i     (rf_rs1),
        .rf_rs2_i     (rf_rs2),
        .ex_valid_i   (ex_valid),
        .ex_rd_i      (ex_q.rd),
        .ex_wen_i     (ex_q.wen),
        .ex_is_load_i (ex_q.is_load),
        .ex_result_i  (ex_result),
        .m_valid_i    (m_valid),
        .m_rd_i       (m_q.rd),
        .m_wen_i      (m_q.wen),
        .m_result_i   (m_result),
        .wb_valid_i   (wb_valid),
        .wb_rd_i      (wb_q.rd),
        .wb_wen_i     (wb_q.wen),
        .wb_result_i  (wb_q.wdata),
        .rs1_val_o    (rs1_val),
        .rs2_val_o    (rs2_val),
        .stall_o      (stall)
    );

    ////////////////////
    // execute, memory, writeback
    ////////////////////
    stage_reg #(.payload_t(ex_payload_t)) ex_reg (
        .clk(clk), .rst_n_i(rst_n_i), .en_i(!mem_busy),
        .valid_i(id_valid && !stall), .data_i(ex_d), .valid_o(ex_valid), .data_o(ex_q)
    );

    execute_unit u_execute (
        .data_i   (ex_q),
        .result_o (ex_result),
        .m_data_o (m_d)
    );

    stage_reg #(.payload_t(m_payload_t)) m_reg (
        .clk(clk), .rst_n_i(rst_n_i), .en_i(!mem_busy),
        .valid_i(ex_valid), .data_i(m_d), .valid_o(m_valid), .data_o(m_q)
    );

    memory_unit u_memory (
        .valid_i      (m_valid),
        .data_i       (m_q),
        .dmem_req_o   (dmem_req_o),
        .dmem_wen_o   (dmem_wen_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_ready_i (dmem_ready_i),
        .mem_busy_o   (mem_busy),
        .result_o     (m_result),
        .wb_data_o    (wb_d)
    );

    // wb always advances, a busy m leaves a bubble behind
    stage_reg #(.payload_t(wb_payload_t)) wb_reg (
        .clk(clk), .rst_n_i(rst_n_i), .en_i(1'b1),
        .valid_i(m_valid && !mem_busy), .data_i(wb_d), .valid_o(wb_valid), .data_o(wb_q)
    );

    ////////////////////
    // commit register
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i || !wb_valid) begin
            wb_commit_o <= 1'b0;
            wb_pc_o     <= '0;
            wb_instr_o  <= '0;
            wb_wen_o    <= 1'b0;
            wb_rd_o     <= '0;
            wb_wdata_o  <= '0;
        end else begin
            wb_commit_o <= 1'b1;
            wb_pc_o     <= wb_q.pc;
            wb_instr_o  <= wb_q.instr;
            wb_wen_o    <= wb_q.wen;
            wb_rd_o     <= wb_q.rd;
            wb_wdata_o  <= wb_q.wen ? wb_q.wdata : '0;  // stores report no value
        end
    end

endmodule

// File: hdl/reg_file.sv
////////////////////
// register file
// 32 x xlen, two async reads, one write, x0 hardwired
////////////////////
module reg_file (
    input  logic                            clk,
    input  logic [core_pkg::REG_ADDR_W-1:0] ra_addr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rb_addr_i,
    output logic [core_pkg::XLEN-1:0]       ra_data_o,
    output logic [core_pkg::XLEN-1:0]       rb_data_o,
    input  logic                            w_en_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] w_addr_i,
    input  logic [core_pkg::XLEN-1:0]       w_data_i
);
    import core_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (w_en_i && w_addr_i != '0) begin
            regs[w_addr_i] <= w_data_i;
        end
    end

    assign ra_data_o = (ra_addr_i == '0) ? '0 : regs[ra_addr_i];
    assign rb_data_o = (rb_addr_i == '0) ? '0 : regs[rb_addr_i];

endmodule

// File: hdl/stage_reg.sv
////////////////////
// pipeline stage register
// valid bit plus one payload, loaded when enabled
////////////////////
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     en_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= valid_i;  // low here is a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            data_o <= data_i;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f files.f --Mdir obj_dir
./obj_dir/Vtb_core | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: tests/tb_core.sv
////////////////////
// core testbench
// runs a small rv64i program twice, once with an always-ready data port
// and once with random wait states, and checks every commit against an ISA model
////////////////////
module tb_core;
    import core_pkg::*;

    localparam int          N_CHECK    = 40;    // commits checked per run
    localparam int          MAX_CYCLES = 2000;
    localparam logic [31:0] NOP        = 32'h0000_0013;  // addi x0, x0, 0

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            wen;
        logic [4:0]      rd;
        logic [XLEN-1:0] val;
        logic            is_st;
        logic [XLEN-1:0] st_addr;
        logic [XLEN-1:0] st_data;
    } expect_t;

    logic                  clk, rst_n_i;
    logic [XLEN-1:0]       imem_addr_o, dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic [ILEN-1:0]       imem_data_i, wb_instr_o;
    logic                  dmem_req_o, dmem_wen_o, dmem_ready_i;
    logic                  wb_commit_o, wb_wen_o;
    logic [XLEN-1:0]       wb_pc_o, wb_wdata_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;

    logic [ILEN-1:0] imem [64];
    logic [XLEN-1:0] dmem [256];
    logic [XLEN-1:0] mregs [32];  // model state
    logic [XLEN-1:0] mmem [256];
    logic [XLEN-1:0] st_addr_q [$];
    logic [XLEN-1:0] st_data_q [$];
    logic [63:0]     rng;
    logic            rand_en, checking, pend_wr;
    logic [XLEN-1:0] pend_addr, pend_data, exp_pc;
    int              errors, timeouts, commits;

    pipeline_core #(.RESET_PC('0)) dut (.*);

    // same-cycle instruction port, no-ops past the program area
    assign imem_data_i = fetch_word(imem_addr_o);

    always #50 clk = ~clk;

    function automatic logic [ILEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
        return (addr[XLEN-1:8] == '0) ? imem[addr[7:2]] : NOP;
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input logic [7:0] idx);
        return {32'(idx) * 32'h9e37_79b9, 24'h5a5a00, idx};
    endfunction

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        return x ^ (x << 17);
    endfunction

    ////////////////////
    // instruction formats
    ////////////////////
    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP;
        end
        imem[0]  = u_word(20'h12345, 5'd1);                          // lui x1
        imem[1]  = i_word(12'd100, 5'd0, 3'b000, 5'd2, 7'h13);       // addi x2, x0, 100
        imem[2]  = i_word(12'hff9, 5'd0, 3'b000, 5'd3, 7'h13);       // addi x3, x0, -7
        imem[3]  = i_word(12'h0f0, 5'd2, 3'b100, 5'd4, 7'h13);       // xori
        imem[4]  = i_word(12'h300, 5'd3, 3'b110, 5'd5, 7'h13);       // ori
        imem[5]  = i_word(12'h7ff, 5'd1, 3'b111, 5'd6, 7'h13);       // andi
        imem[6]  = r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd7);          // add x7, x1, x2
        imem[7]  = r_word(7'h20, 5'd3, 5'd7, 3'b000, 5'd8);          // sub, x7 from ex
        imem[8]  = r_word(7'h00, 5'd7, 5'd8, 3'b100, 5'd9);          // xor, ex and m
        imem[9]  = r_word(7'h00, 5'd8, 5'd9, 3'b110, 5'd10);         // or
        imem[10] = i_word(12'd5, 5'd0, 3'b000, 5'd11, 7'h13);
        imem[11] = r_word(7'h00, 5'd11, 5'd10, 3'b111, 5'd12);       // and
        imem[12] = i_word(12'd33, 5'd7, 3'b000, 5'd0, 7'h13);        // write to x0
        imem[13] = r_word(7'h00, 5'd2, 5'd0, 3'b000, 5'd13);         // reads x0
        imem[14] = i_word(12'd64, 5'd0, 3'b000, 5'd14, 7'h13);       // base address
        imem[15] = s_word(12'd0, 5'd7, 5'd14);                       // sd x7, 0(x14)
        imem[16] = s_word(12'd8, 5'd13, 5'd14);
        imem[17] = i_word(12'd0, 5'd14, 3'b011, 5'd15, 7'h03);       // ld x15, 0(x14)
        imem[18] = r_word(7'h00, 5'd2, 5'd15, 3'b000, 5'd16);        // load-use
        imem[19] = i_word(12'd8, 5'd14, 3'b011, 5'd17, 7'h03);
        imem[20] = r_word(7'h20, 5'd15, 5'd17, 3'b000, 5'd18);       // load-use
        imem[21] = i_word(12'd24, 5'd14, 3'b011, 5'd19, 7'h03);      // never stored
        imem[22] = s_word(12'hff8, 5'd19, 5'd14);                    // store data load-use
        imem[23] = i_word(12'hff8, 5'd14, 3'b011, 5'd20, 7'h03);
        imem[24] = r_word(7'h01, 5'd3, 5'd2, 3'b000, 5'd2);          // mul, unsupported
        imem[25] = i_word(12'd1, 5'd0, 3'b000, 5'd2, 7'h0b);         // custom opcode
        imem[26] = r_word(7'h00, 5'd20, 5'd2, 3'b000, 5'd21);        // x2 must be 100
    endtask

    ////////////////////
    // reference model
    ////////////////////
    function automatic expect_t ref_step(input logic [XLEN-1:0] pc);
        logic [ILEN-1:0] ins;
        logic [XLEN-1:0] a, b, imm_i, imm_s, res, addr;
        logic            legal;
        expect_t         e;
        ins   = fetch_word(pc);
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        legal = 1'b1;
        res   = '0;
        e     = '0;
        e.pc  = pc;
        case (ins[6:0])
            7'h37: res = {{32{ins[31]}}, ins[31:12], 12'h000};
            7'h13: begin
                case (ins[14:12])
                    3'b000:  res = a + imm_i;
                    3'b100:  res = a ^ imm_i;
                    3'b110:  res = a | imm_i;
                    3'b111:  res = a & imm_i;
                    default: legal = 1'b0;
                endcase
            end
            7'h33: begin
                case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    10'b0000000_100: res = a ^ b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_111: res = a & b;
                    default:         legal = 1'b0;
                endcase
            end
            7'h03: begin
                legal = (ins[14:12] == 3'b011);
                addr  = a + imm_i;
                res   = mmem[addr[10:3]];
            end
            7'h23: begin
                legal = (ins[14:12] == 3'b011);
                addr  = a + imm_s;
                if (legal) begin
                    e.is_st           = 1'b1;
                    e.st_addr         = addr;
                    e.st_data         = b;
                    mmem[addr[10:3]]  = b;
                end
            end
            default: legal = 1'b0;
        endcase
        e.wen = legal && ins[6:0] != 7'h23 && ins[11:7] != 5'd0;
        if (e.wen) begin
            e.rd            = ins[11:7];
            e.val           = res;
            mregs[ins[11:7]] = res;
        end
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] want);
        $display("Fail t=%0t %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    ////////////////////
    // data memory
    ////////////////////
    always @(negedge clk) begin
        logic rdy;
        if (rand_en) begin
            rng = xorshift64(rng);
            rdy = (rng[2:0] > 3'd2);  // low about 3 cycles in 8
        end else begin
            rdy = 1'b1;
        end
        dmem_ready_i <= rdy;
        dmem_rdata_i <= dmem[dmem_addr_o[10:3]];
        pend_wr      <= dmem_req_o && dmem_wen_o && rdy;
        pend_addr    <= dmem_addr_o;
        pend_data    <= dmem_wdata_o;
        if (dmem_req_o && dmem_wen_o && rdy) begin
            st_addr_q.push_back(dmem_addr_o);
            st_data_q.push_back(dmem_wdata_o);
        end
    end

    always @(posedge clk) begin
        if (pend_wr) begin
            dmem[pend_addr[10:3]] <= pend_data;  // access completes on this edge
        end
    end

    // commit compare
    always @(negedge clk) begin
        expect_t         e;
        logic [XLEN-1:0] got_addr, got_data;
        if (checking && wb_commit_o) begin
            e = ref_step(exp_pc);
            if (wb_pc_o !== e.pc) report_mismatch("wb_pc_o", wb_pc_o, e.pc);
            if (wb_instr_o !== fetch_word(e.pc)) begin
                report_mismatch("wb_instr_o", XLEN'(wb_instr_o), XLEN'(fetch_word(e.pc)));
            end
            if (wb_wen_o !== e.wen) report_mismatch("wb_wen_o", XLEN'(wb_wen_o), XLEN'(e.wen));
            if (e.wen && wb_rd_o !== e.rd) report_mismatch("wb_rd_o", XLEN'(wb_rd_o), XLEN'(e.rd));
            if (e.wen && wb_wdata_o !== e.val) report_mismatch("wb_wdata_o", wb_wdata_o, e.val);
            if (e.is_st) begin
                if (st_addr_q.size() == 0) begin
                    $display("store at pc %h committed but never reached the data port", e.pc);
                    errors++;
                end else begin
                    got_addr = st_addr_q.pop_front();
                    got_data = st_data_q.pop_front();
                    if (got_addr !== e.st_addr) report_mismatch("dmem_addr_o", got_addr, e.st_addr);
                    if (got_data !== e.st_data) report_mismatch("dmem_wdata_o", got_data, e.st_data);
                end
            end
            exp_pc = exp_pc + 4;
            commits++;
        end
    end

    task automatic run_phase(input logic random_ready, input int phase);
        int cycles;
        checking = 1'b0;
        rand_en  = random_ready;
        rst_n_i  = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(8'(i));
            mmem[i] = fill_word(8'(i));
        end
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        st_addr_q.delete();
        st_data_q.delete();
        exp_pc  = '0;
        commits = 0;
        repeat (3) @(negedge clk);
        checking = 1'b1;
        rst_n_i  = 1'b1;
        cycles   = 0;
        while (commits < N_CHECK && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (commits < N_CHECK) begin
            $display("timeout in run %0d, only %0d commits seen", phase, commits);
            timeouts++;
        end
        if (st_addr_q.size() != 0) begin
            $display("run %0d saw %0d stores with no matching commit", phase, st_addr_q.size());
            errors++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        dmem_ready_i = 1'b0;
        dmem_rdata_i = '0;
        pend_wr      = 1'b0;
        pend_addr    = '0;
        pend_data    = '0;
        checking     = 1'b0;
        rand_en      = 1'b0;
        rng          = 64'd65270;
        errors       = 0;
        timeouts     = 0;
        exp_pc       = '0;
        load_program();
        @(negedge clk);
        run_phase(1'b0, 1);  // ready always high
        run_phase(1'b1, 2);  // random wait states
        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tests/tb_core_props.sv
////////////////////
// core port properties
// reset state, data port hold and idle commit fields
////////////////////
module tb_core_props (
    input logic                            clk,
    input logic                            rst_n_i,
    input logic                            dmem_req_o,
    input logic                            dmem_wen_o,
    input logic [core_pkg::XLEN-1:0]       dmem_addr_o,
    input logic [core_pkg::XLEN-1:0]       dmem_wdata_o,
    input logic                            dmem_ready_i,
    input logic                            wb_commit_o,
    input logic [core_pkg::XLEN-1:0]       wb_pc_o,
    input logic [core_pkg::ILEN-1:0]       wb_instr_o,
    input logic                            wb_wen_o,
    input logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
    input logic [core_pkg::XLEN-1:0]       wb_wdata_o
);

    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !wb_commit_o && !dmem_req_o && !dmem_wen_o)
        else $error("core outputs active after reset");

    // a waiting access keeps its address
    held_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o && !dmem_ready_i |=> dmem_req_o && $stable(dmem_addr_o))
        else $error("data port address changed while waiting");

    held_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o && dmem_wen_o && !dmem_ready_i |=> $stable(dmem_wdata_o))
        else $error("store data changed while waiting");

    idle_commit: assert property (@(posedge clk) disable iff (!rst_n_i)
        !wb_commit_o |-> wb_pc_o == '0 && wb_instr_o == '0 && !wb_wen_o
                         && wb_rd_o == '0 && wb_wdata_o == '0)
        else $error("commit fields not zero without a commit");

endmodule

bind pipeline_core tb_core_props props (.*);
